// File: all.f
gp_pkg.sv
cmd_apb_slave.sv
cmd_fifo.sv
task_decoder.sv
dispatch_top.sv
tb_dispatch.sv

// File: cmd_apb_slave.sv
`timescale 1ns/1ns

module cmd_apb_slave (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [15:0]      pwdata,
    output logic [15:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             push,
    output gp_pkg::cmd_t     push_data,
    input  logic             full,
    input  gp_pkg::status_t  status
);

    logic addr_cmd;
    logic addr_status;
    logic cmd_write;
    logic cmd_done;

    assign addr_cmd    = (paddr == gp_pkg::apb_addr_cmd);
    assign addr_status = (paddr == gp_pkg::apb_addr_status);

    // command write in either phase of the access.
    assign cmd_write = psel && pwrite && addr_cmd;

    // back-pressure while the fifo has no room.
    assign pready  = !(cmd_write && full);
    assign pslverr = psel && penable && !addr_cmd && !addr_status;

    // completing access phase of a command write.
    assign cmd_done = cmd_write && penable && !full;

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= cmd_done;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_done) begin
            push_data <= gp_pkg::cmd_t'(pwdata);
        end
    end

    // status is sampled in the setup phase so reads finish at once.
    always_ff @(posedge clk) begin
        if (psel && !penable && !pwrite) begin
            prdata <= status;
        end
    end

endmodule

// File: cmd_fifo.sv
`timescale 1ns/1ns

module cmd_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          push,
    input  gp_pkg::cmd_t  push_data,
    input  logic          pop,
    output gp_pkg::cmd_t  head,
    output logic          empty,
    output logic          full,
    output logic [3:0]    level
);

    localparam int ptr_w = $clog2(fifo_depth);

    gp_pkg::cmd_t     mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [3:0]       count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = mem[rd_ptr];
    assign empty = (count == 4'd0);
    assign full  = (count == 4'(fifo_depth));
    assign level = count;

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 4'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 4'd1;
            end else if (do_pop && !do_push) begin
                count <= count - 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: dispatch_top.sv
`timescale 1ns/1ns

module dispatch_top #(
    parameter int num_pe     = 8,
    parameter int fifo_depth = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [3:0]        paddr,
    input  logic [15:0]       pwdata,
    output logic [15:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output gp_pkg::rs_task_t  rs_task,
    output logic              mem_req,
    input  logic              grant,
    output gp_pkg::mem_pkt_t  mem_pkt,
    input  logic              bank_busy,
    input  logic              rs_empty,
    input  logic [num_pe-1:0] pe_idle,
    input  logic              stream_end,
    input  logic              vertex_done,
    output logic              cntl_done
);

    logic            push;
    gp_pkg::cmd_t    push_data;
    logic            pop;
    gp_pkg::cmd_t    head;
    logic            empty;
    logic            full;
    logic [3:0]      level;
    gp_pkg::status_t status;

    cmd_apb_slave u_slave (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .push(push), .push_data(push_data), .full(full), .status(status)
    );

    cmd_fifo #(.fifo_depth(fifo_depth)) u_fifo (
        .clk(clk), .reset(reset),
        .push(push), .push_data(push_data), .pop(pop), .head(head),
        .empty(empty), .full(full), .level(level)
    );

    task_decoder #(.num_pe(num_pe)) u_decoder (
        .clk(clk), .reset(reset),
        .head(head), .empty(empty), .pop(pop), .rs_task(rs_task),
        .mem_req(mem_req), .grant(grant), .mem_pkt(mem_pkt),
        .bank_busy(bank_busy), .rs_empty(rs_empty), .pe_idle(pe_idle),
        .stream_end(stream_end), .vertex_done(vertex_done), .cntl_done(cntl_done),
        .level(level), .status(status)
    );

endmodule

// File: gp_pkg.sv
package gp_pkg;

    // command opcodes, carried in the top two bits of a packet.
    localparam logic [1:0] op_task   = 2'd0;
    localparam logic [1:0] op_replay = 2'd1;
    localparam logic [1:0] op_set_fv = 2'd2;
    localparam logic [1:0] op_set_wb = 2'd3;

    // apb register map.
    localparam logic [3:0] apb_addr_cmd    = 4'h0;
    localparam logic [3:0] apb_addr_status = 4'h4;

    // host command packet.
    typedef struct packed {
        logic [1:0] opcode;
        logic [3:0] iter_mask;
        logic [9:0] body;
    } cmd_t;

    // task sent to the reservation station, opcode stripped.
    typedef struct packed {
        logic        valid;
        logic [13:0] data;
    } rs_task_t;

    // fetch or replay packet sent to memory.
    typedef struct packed {
        logic valid;
        cmd_t packet;
    } mem_pkt_t;

    // status word returned on apb reads.
    typedef struct packed {
        logic [1:0] replay_iter;
        logic [3:0] num_fv;
        logic [3:0] weights_boundary;
        logic       replay_active;
        logic [3:0] fifo_level;
        logic       spare;
    } status_t;

endpackage

// File: run.sh
#!/bin/bash
rm -f sim.log
verilator --binary --timing --top-module tb_dispatch -f all.f -o tb_dispatch_sim || exit 1
./obj_dir/tb_dispatch_sim > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: task_decoder.sv
`timescale 1ns/1ns

module task_decoder #(
    parameter int num_pe = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  gp_pkg::cmd_t      head,
    input  logic              empty,
    output logic              pop,
    output gp_pkg::rs_task_t  rs_task,
    output logic              mem_req,
    input  logic              grant,
    output gp_pkg::mem_pkt_t  mem_pkt,
    input  logic              bank_busy,
    input  logic              rs_empty,
    input  logic [num_pe-1:0] pe_idle,
    input  logic              stream_end,
    input  logic              vertex_done,
    output logic              cntl_done,
    input  logic [3:0]        level,
    output gp_pkg::status_t   status
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_grant,
        st_wait_drain,
        st_wait_stream,
        st_wait_vertex
    } state_t;

    state_t       state;
    state_t       state_d;
    gp_pkg::cmd_t pkt_q;
    logic [1:0]   replay_iter;
    logic [3:0]   num_fv;
    logic [3:0]   weights_boundary;
    logic         rs_valid_q;
    logic [13:0]  rs_data_q;
    logic         mask_hit;
    logic         drained;
    logic         last_iter;

    // head is accepted only while idle.
    assign pop = (state == st_idle) && !empty;

    assign mask_hit  = head.iter_mask[replay_iter];
    assign drained   = !bank_busy && rs_empty && (&pe_idle);
    assign last_iter = (replay_iter == 2'd3);

    always_comb begin
        state_d = state;
        case (state)
            st_idle: begin
                if (pop) begin
                    if (head.opcode == gp_pkg::op_task && !mask_hit) begin
                        state_d = st_wait_grant;
                    end else if (head.opcode == gp_pkg::op_replay) begin
                        state_d = st_wait_drain;
                    end
                end
            end
            st_wait_grant: begin
                if (grant) begin
                    state_d = st_idle;
                end
            end
            st_wait_drain: begin
                if (drained) begin
                    state_d = last_iter ? st_wait_vertex : st_wait_stream;
                end
            end
            st_wait_stream: begin
                if (stream_end) begin
                    state_d = st_idle;
                end
            end
            st_wait_vertex: begin
                if (vertex_done) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= st_idle;
            replay_iter      <= 2'd0;
            num_fv           <= 4'd0;
            weights_boundary <= 4'd0;
            rs_valid_q       <= 1'b0;
        end else begin
            state      <= state_d;
            rs_valid_q <= pop && head.opcode == gp_pkg::op_task && mask_hit;
            if (pop && head.opcode == gp_pkg::op_set_fv) begin
                num_fv <= head.body[3:0];
            end
            if (pop && head.opcode == gp_pkg::op_set_wb) begin
                weights_boundary <= head.body[3:0];
            end
            if (state == st_wait_drain && drained && !last_iter) begin
                replay_iter <= replay_iter + 2'd1;
            end else if (state == st_wait_vertex && vertex_done) begin
                replay_iter <= 2'd0;
            end
        end
    end

    // the popped packet is kept for a later fetch or replay.
    always_ff @(posedge clk) begin
        if (pop) begin
            pkt_q     <= head;
            rs_data_q <= head[13:0];
        end
    end

    assign rs_task.valid = rs_valid_q;
    assign rs_task.data  = rs_data_q;

    assign mem_req = (state == st_wait_grant);

    // fetch leaves on grant, replay leaves once drained.
    assign mem_pkt.valid  = (state == st_wait_grant && grant)
                          || (state == st_wait_drain && drained && !last_iter);
    assign mem_pkt.packet = pkt_q;

    assign cntl_done = (state == st_wait_drain) && drained && last_iter;

    assign status.replay_iter      = replay_iter;
    assign status.num_fv           = num_fv;
    assign status.weights_boundary = weights_boundary;
    assign status.replay_active    = (state == st_wait_drain) || (state == st_wait_stream)
                                   || (state == st_wait_vertex);
    assign status.fifo_level       = level;
    assign status.spare            = 1'b0;

endmodule

// File: tb_dispatch.sv
`timescale 1ns/1ns

module tb_dispatch;

    localparam int num_pe     = 8;
    localparam int fifo_depth = 8;
    localparam int timeout    = 100;
    // outputs that tests wait on.
    localparam int sel_rs   = 0;
    localparam int sel_req  = 1;
    localparam int sel_pkt  = 2;
    localparam int sel_done = 3;

    logic              clk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [3:0]        paddr;
    logic [15:0]       pwdata;
    logic [15:0]       prdata;
    logic              pready;
    logic              pslverr;
    gp_pkg::rs_task_t  rs_task;
    logic              mem_req;
    logic              grant;
    gp_pkg::mem_pkt_t  mem_pkt;
    logic              bank_busy;
    logic              rs_empty;
    logic [num_pe-1:0] pe_idle;
    logic              stream_end;
    logic              vertex_done;
    logic              cntl_done;
    logic [31:0]       rng_state;
    logic [3:0]        fv_val;
    logic [3:0]        wb_val;

    dispatch_top #(.num_pe(num_pe), .fifo_depth(fifo_depth)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic gp_pkg::cmd_t make_pkt(input logic [1:0] op, input logic [3:0] mask);
        logic [31:0] r;
        r = next_rand();
        return {op, mask, r[9:0]};
    endfunction

    function automatic gp_pkg::status_t make_status(input logic [1:0] iter, input logic active,
                                                    input logic [3:0] lvl);
        return {iter, fv_val, wb_val, active, lvl, 1'b0};
    endfunction

    function automatic logic sig_value(input int sel);
        case (sel)
            sel_rs:  return rs_task.valid;
            sel_req: return mem_req;
            sel_pkt: return mem_pkt.valid;
            default: return cntl_done;
        endcase
    endfunction

    task automatic error_stop(input string msg);
        $display("ERROR: %s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rs_task(input string name, input gp_pkg::rs_task_t exp,
                                 input gp_pkg::rs_task_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            error_stop("rs_task mismatch");
        end
    endtask

    task automatic check_mem_pkt(input string name, input gp_pkg::mem_pkt_t exp,
                                 input gp_pkg::mem_pkt_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            error_stop("mem_pkt mismatch");
        end
    endtask

    task automatic check_status(input string name, input gp_pkg::status_t exp,
                                input gp_pkg::status_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            error_stop("status mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            error_stop("flag mismatch");
        end
    endtask

    task automatic wait_high(input int sel, input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
            if (n > timeout) error_stop({"timeout waiting for ", what});
        end while (!sig_value(sel));
    endtask

    task automatic expect_quiet(input int sel, input int cycles, input string what);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            if (sig_value(sel)) error_stop({what, " went high when it should stay low"});
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [15:0] data);
        int n;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        check_flag("apb_write pslverr", 1'b0, pslverr);
        n = 0;
        // pready low means the FIFO is full.
        while (!pready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > timeout) error_stop("APB write never completed");
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [15:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        data    = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_and_check_status(input string name, input gp_pkg::status_t exp);
        logic [15:0] word;
        apb_read(gp_pkg::apb_addr_status, word);
        check_status(name, exp, gp_pkg::status_t'(word));
    endtask

    // arbiter model that grants the pending fetch after a random delay.
    task automatic grant_fetch(input string name, input gp_pkg::cmd_t exp);
        logic [31:0] r;
        wait_high(sel_req, "mem_req");
        if (rs_task.valid) error_stop("rs_task went high for a fetch task");
        r = next_rand();
        repeat (r[1:0]) begin
            @(posedge clk);
            #2;
            if (rs_task.valid) error_stop("rs_task went high for a fetch task");
        end
        @(posedge clk);
        #1;
        grant = 1'b1;
        #1;
        check_mem_pkt(name, {1'b1, exp}, mem_pkt);
        @(posedge clk);
        #1;
        grant = 1'b0;
    endtask

    task automatic pulse_stream_end();
        @(posedge clk);
        #1;
        stream_end = 1'b1;
        @(posedge clk);
        #1;
        stream_end = 1'b0;
    endtask

    task automatic replay_step(input string name);
        gp_pkg::cmd_t p;
        p = make_pkt(gp_pkg::op_replay, 4'b0000);
        apb_write(gp_pkg::apb_addr_cmd, p);
        wait_high(sel_pkt, "replay mem_pkt");
        check_mem_pkt(name, {1'b1, p}, mem_pkt);
        pulse_stream_end();
    endtask

    task automatic config_registers();
        gp_pkg::cmd_t fv_pkt;
        gp_pkg::cmd_t wb_pkt;
        fv_pkt = make_pkt(gp_pkg::op_set_fv, 4'b1111);
        wb_pkt = make_pkt(gp_pkg::op_set_wb, 4'b0000);
        fv_val = fv_pkt.body[3:0];
        wb_val = wb_pkt.body[3:0];
        apb_write(gp_pkg::apb_addr_cmd, fv_pkt);
        apb_write(gp_pkg::apb_addr_cmd, wb_pkt);
        // the last packet reaches the head, then applies one cycle after its pop.
        @(posedge clk);
        read_and_check_status("config", make_status(2'd0, 1'b0, 4'd0));
    endtask

    task automatic reject_bad_address();
        gp_pkg::cmd_t p;
        p = make_pkt(gp_pkg::op_task, 4'b1111);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = 4'h8;
        pwdata  = p;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        check_flag("bad address pslverr", 1'b1, pslverr);
        check_flag("bad address pready", 1'b1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        expect_quiet(sel_rs, 4, "rs_task after a rejected write");
        read_and_check_status("bad address", make_status(2'd0, 1'b0, 4'd0));
    endtask

    task automatic forward_task();
        gp_pkg::cmd_t p;
        p = make_pkt(gp_pkg::op_task, 4'b0101);
        apb_write(gp_pkg::apb_addr_cmd, p);
        wait_high(sel_rs, "rs_task");
        check_rs_task("forward", {1'b1, p.iter_mask, p.body}, rs_task);
        expect_quiet(sel_req, 4, "mem_req");
    endtask

    task automatic fetch_task();
        gp_pkg::cmd_t p;
        p = make_pkt(gp_pkg::op_task, 4'b1010);
        apb_write(gp_pkg::apb_addr_cmd, p);
        grant_fetch("fetch", p);
    endtask

    task automatic replay_iteration();
        gp_pkg::cmd_t rp;
        gp_pkg::cmd_t tp;
        rp = make_pkt(gp_pkg::op_replay, 4'b0000);
        tp = make_pkt(gp_pkg::op_task, 4'b0010);
        @(posedge clk);
        #1;
        pe_idle = 8'h7f;
        apb_write(gp_pkg::apb_addr_cmd, rp);
        apb_write(gp_pkg::apb_addr_cmd, tp);
        expect_quiet(sel_pkt, 6, "mem_pkt during the drain wait");
        @(posedge clk);
        #1;
        pe_idle = '1;
        #1;
        check_mem_pkt("replay", {1'b1, rp}, mem_pkt);
        read_and_check_status("replay status", make_status(2'd1, 1'b1, 4'd1));
        expect_quiet(sel_rs, 6, "rs_task before stream_end");
        pulse_stream_end();
        // iteration 1 now selects mask bit 1.
        wait_high(sel_rs, "queued rs_task");
        check_rs_task("replay queued task", {1'b1, tp.iter_mask, tp.body}, rs_task);
    endtask

    task automatic final_replay();
        gp_pkg::cmd_t p;
        replay_step("replay 2");
        replay_step("replay 3");
        p = make_pkt(gp_pkg::op_replay, 4'b0000);
        apb_write(gp_pkg::apb_addr_cmd, p);
        wait_high(sel_done, "cntl_done");
        if (mem_pkt.valid) error_stop("mem_pkt went high on the final replay");
        read_and_check_status("final replay", make_status(2'd3, 1'b1, 4'd0));
        @(posedge clk);
        #1;
        vertex_done = 1'b1;
        @(posedge clk);
        #1;
        vertex_done = 1'b0;
        read_and_check_status("after vertex_done", make_status(2'd0, 1'b0, 4'd0));
    endtask

    task automatic backpressure_order();
        gp_pkg::cmd_t sent[$];
        gp_pkg::cmd_t p;
        int i;
        // one task waits in the decoder while the rest fill the FIFO.
        for (i = 0; i < fifo_depth + 1; i++) begin
            p = make_pkt(gp_pkg::op_task, 4'b1110);
            sent.push_back(p);
            apb_write(gp_pkg::apb_addr_cmd, p);
        end
        p = make_pkt(gp_pkg::op_task, 4'b0110);
        sent.push_back(p);
        fork
            apb_write(gp_pkg::apb_addr_cmd, p);
            begin
                repeat (5) begin
                    @(posedge clk);
                    #2;
                    if (pready) error_stop("pready high while the FIFO is full");
                end
                grant_fetch("backpressure 0", sent[0]);
            end
        join
        for (i = 1; i < sent.size(); i++) begin
            grant_fetch($sformatf("backpressure %0d", i), sent[i]);
        end
    endtask

    initial begin
        rng_state   = 32'd36782;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        grant       = 1'b0;
        bank_busy   = 1'b0;
        rs_empty    = 1'b1;
        pe_idle     = '1;
        stream_end  = 1'b0;
        vertex_done = 1'b0;
        fv_val      = '0;
        wb_val      = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        config_registers();
        reject_bad_address();
        forward_task();
        fetch_task();
        replay_iteration();
        final_replay();
        backpressure_order();
        $display("Testbench passed");
        $finish;
    end

endmodule
